// File: source/fetch_pkg.sv
// shared widths, address fields, bus structs and FSM states for the instruction fetch unit
package fetch_pkg;

    // byte address, only bits 17 to 0 reach the cache
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // one byte from instruction memory
    typedef logic [7:0] byte_t;

    // cache line select and tag
    typedef logic [7:0] index_t;
    typedef logic [7:0] tag_t;

    // direct-mapped geometry, one word per line
    localparam int CACHE_LINES = 256;

    // address split, index is bits 9..2 and tag is bits 17..10
    localparam int INDEX_LSB = 2;
    localparam int TAG_LSB   = 10;
    localparam int TAG_MSB   = 17;

    // returned on a lookup miss
    localparam inst_t ZERO_WORD = '0;

    // line write from the controller into the cache
    typedef struct packed {
        addr_t addr;
        inst_t inst;
    } cache_fill_t;

    // byte read request to instruction memory
    typedef struct packed {
        logic  rd;
        addr_t addr;
    } mem_req_t;

    // fetch controller states
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT_LAST,
        RESPOND
    } fetch_state_e;

endpackage

// File: source/inst_cache.sv
// direct-mapped instruction cache, combinational lookup and clocked line fill
`timescale 1ns/100ps

module inst_cache (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  fetch_pkg::addr_t       query_addr_i,
    input  logic                   fill_en_i,
    input  fetch_pkg::cache_fill_t fill_i,
    output logic                   hit_o,
    output fetch_pkg::inst_t       inst_o
);

    // line storage
    fetch_pkg::inst_t data_q [fetch_pkg::CACHE_LINES];
    fetch_pkg::tag_t  tag_q  [fetch_pkg::CACHE_LINES];
    logic [fetch_pkg::CACHE_LINES-1:0] valid_q;

    // query side fields
    fetch_pkg::index_t q_index;
    fetch_pkg::tag_t   q_tag;

    // fill side fields
    fetch_pkg::index_t f_index;
    fetch_pkg::tag_t   f_tag;

    assign q_index = query_addr_i[fetch_pkg::TAG_LSB-1:fetch_pkg::INDEX_LSB];
    assign q_tag   = query_addr_i[fetch_pkg::TAG_MSB:fetch_pkg::TAG_LSB];
    assign f_index = fill_i.addr[fetch_pkg::TAG_LSB-1:fetch_pkg::INDEX_LSB];
    assign f_tag   = fill_i.addr[fetch_pkg::TAG_MSB:fetch_pkg::TAG_LSB];

    // valid bits start cleared so the first access to each line misses
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_en_i) begin
            valid_q[f_index] <= 1'b1;
        end
    end

    // data and tag written together with the valid bit
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            data_q[f_index] <= fill_i.inst;
            tag_q[f_index]  <= f_tag;
        end
    end

    // lookup, a fill shows up from the cycle after the fill edge
    always_comb begin
        if (valid_q[q_index] && (tag_q[q_index] == q_tag)) begin
            hit_o  = 1'b1;
            inst_o = data_q[q_index];
        end else begin
            hit_o  = 1'b0;
            inst_o = fetch_pkg::ZERO_WORD;
        end
    end

    // an X on the fill strobe would corrupt a line silently
    a_fill_en_known : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(fill_en_i)
    ) else $error("inst_cache fill strobe unknown");

endmodule

// File: source/byte_assembler.sv
// shift register that packs four memory bytes into one little-endian instruction word
`timescale 1ns/100ps

module byte_assembler (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              shift_i,
    input  fetch_pkg::byte_t  byte_i,
    output fetch_pkg::inst_t  word_o
);

    // assembled word
    fetch_pkg::inst_t word_q;

    // new byte enters at the top, older ones move down
    // after four shifts the first byte lands in bits 7..0
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            word_q <= '0;
        end else if (shift_i) begin
            word_q <= {byte_i, word_q[31:8]};
        end
    end

    assign word_o = word_q;

endmodule

// File: source/fetch_ctrl.sv
// fetch FSM, picks hit or miss, runs the four byte reads, fills the cache and returns the word
`timescale 1ns/100ps

module fetch_ctrl (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   fetch_req_i,
    input  fetch_pkg::addr_t       pc_i,
    input  logic                   cache_hit_i,
    input  fetch_pkg::inst_t       cache_inst_i,
    input  fetch_pkg::inst_t       asm_word_i,
    output fetch_pkg::addr_t       query_addr_o,
    output logic                   fill_en_o,
    output fetch_pkg::cache_fill_t fill_o,
    output logic                   shift_o,
    output fetch_pkg::mem_req_t    mem_req_o,
    output logic                   ready_o,
    output logic                   inst_valid_o,
    output fetch_pkg::inst_t       inst_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;

    // word address of the miss in flight
    fetch_pkg::addr_t base_q;

    // byte reads issued and bytes shifted in
    logic [1:0] rd_cnt_q;
    logic [1:0] ret_cnt_q;

    logic accept;

    // only IDLE takes new requests, strobes while busy are dropped
    assign ready_o = (state_q == fetch_pkg::IDLE);
    assign accept  = ready_o && fetch_req_i;

    // cache is always looked up with the live pc
    assign query_addr_o = pc_i;

    // one byte read per READ cycle, pc+0 to pc+3
    assign mem_req_o.rd   = (state_q == fetch_pkg::READ);
    assign mem_req_o.addr = base_q + fetch_pkg::addr_t'(rd_cnt_q);

    // memory answers one cycle after each read
    assign shift_o = ((state_q == fetch_pkg::READ) && (rd_cnt_q != 2'd0)) ||
                     (state_q == fetch_pkg::WAIT_LAST);

    // line write in RESPOND
    assign fill_en_o   = (state_q == fetch_pkg::RESPOND);
    assign fill_o.addr = base_q;
    assign fill_o.inst = asm_word_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (accept && !cache_hit_i) begin
                    state_d = fetch_pkg::READ;
                end
            end
            fetch_pkg::READ: begin
                // fourth read goes out this cycle
                if (rd_cnt_q == 2'd3) begin
                    state_d = fetch_pkg::WAIT_LAST;
                end
            end
            fetch_pkg::WAIT_LAST: begin
                // last byte shifts in at this edge
                if (ret_cnt_q == 2'd3) begin
                    state_d = fetch_pkg::RESPOND;
                end
            end
            default: begin
                state_d = fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= fetch_pkg::IDLE;
            rd_cnt_q  <= 2'd0;
            ret_cnt_q <= 2'd0;
        end else begin
            state_q <= state_d;
            // both counters wrap back to zero after four steps
            if (state_q == fetch_pkg::READ) begin
                rd_cnt_q <= rd_cnt_q + 2'd1;
            end
            if (shift_o) begin
                ret_cnt_q <= ret_cnt_q + 2'd1;
            end
        end
    end

    // response pulse, hit at acceptance or miss in RESPOND
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= (accept && cache_hit_i) || (state_q == fetch_pkg::RESPOND);
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            base_q <= {pc_i[31:2], 2'b00};
        end
        if (accept && cache_hit_i) begin
            inst_o <= cache_inst_i;
        end else if (state_q == fetch_pkg::RESPOND) begin
            inst_o <= asm_word_i;
        end
    end

    // no memory traffic while idle, both counters rewound for the next miss
    a_no_read_idle : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == fetch_pkg::IDLE) |->
            (!mem_req_o.rd && (rd_cnt_q == 2'd0) && (ret_cnt_q == 2'd0))
    ) else $error("memory read or stale counter while idle");

    // a miss issues exactly four back-to-back reads
    a_four_reads : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (accept && !cache_hit_i) |=> mem_req_o.rd [*4] ##1 !mem_req_o.rd
    ) else $error("miss did not issue four reads");

    // miss pulse lasts one cycle unless a hit follows right behind it
    a_single_miss_pulse : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == fetch_pkg::RESPOND) |=> inst_valid_o ##1
            (!inst_valid_o || $past(fetch_req_i && cache_hit_i))
    ) else $error("miss response pulse held too long");

endmodule

// File: source/fetch_unit.sv
// fetch unit top, ties the controller, cache and byte assembler to the CPU and memory ports
`timescale 1ns/100ps

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 fetch_req_i,
    input  fetch_pkg::addr_t     pc_i,
    output logic                 ready_o,
    output logic                 inst_valid_o,
    output fetch_pkg::inst_t     inst_o,
    output fetch_pkg::mem_req_t  mem_req_o,
    input  fetch_pkg::byte_t     mem_data_i
);

    // controller to cache
    fetch_pkg::addr_t       query_addr;
    logic                   fill_en;
    fetch_pkg::cache_fill_t fill;

    // cache back to controller
    logic                   cache_hit;
    fetch_pkg::inst_t       cache_inst;

    // assembler handshake
    logic                   shift;
    fetch_pkg::inst_t       asm_word;

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_req_i  (fetch_req_i),
        .pc_i         (pc_i),
        .cache_hit_i  (cache_hit),
        .cache_inst_i (cache_inst),
        .asm_word_i   (asm_word),
        .query_addr_o (query_addr),
        .fill_en_o    (fill_en),
        .fill_o       (fill),
        .shift_o      (shift),
        .mem_req_o    (mem_req_o),
        .ready_o      (ready_o),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o)
    );

    inst_cache u_cache (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .query_addr_i (query_addr),
        .fill_en_i    (fill_en),
        .fill_i       (fill),
        .hit_o        (cache_hit),
        .inst_o       (cache_inst)
    );

    // bytes come straight from memory
    byte_assembler u_asm (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .shift_i (shift),
        .byte_i  (mem_data_i),
        .word_o  (asm_word)
    );

endmodule

// File: bench/tb_fetch_unit.sv
// testbench for the fetch unit, random fetches checked against a byte memory model and a reference cache
`timescale 1ns/100ps

module tb_fetch_unit;

    localparam int          N_REQ        = 400;
    localparam int          MAX_GAP      = 3;
    localparam int          RESET_CYCLES = 16;
    // request cycle, six wait cycles and the response cycle of a miss
    localparam int          REQ_CYCLES   = 8;
    localparam int          TIMEOUT_CYCLES = N_REQ * (REQ_CYCLES + MAX_GAP) + RESET_CYCLES + 100;
    localparam int          MEM_BYTES    = 1 << 18;
    localparam logic [31:0] SEED         = 32'h4104_17ee;

    logic                clk;
    logic                rst_n_i;
    logic                fetch_req_i;
    fetch_pkg::addr_t    pc_i;
    logic                ready_o;
    logic                inst_valid_o;
    fetch_pkg::inst_t    inst_o;
    fetch_pkg::mem_req_t mem_req_o;
    fetch_pkg::byte_t    mem_data_i;

    // byte memory and the read it owes for the next cycle
    fetch_pkg::byte_t mem [MEM_BYTES];
    logic             rd_pend;
    logic [17:0]      rd_addr;

    // reference cache
    logic             valid_m [fetch_pkg::CACHE_LINES];
    fetch_pkg::tag_t  tag_m   [fetch_pkg::CACHE_LINES];
    fetch_pkg::inst_t data_m  [fetch_pkg::CACHE_LINES];

    // byte addresses the coming memory reads must carry
    fetch_pkg::addr_t exp_rd_q [$];

    // small pools so that repeats and conflicts are frequent
    fetch_pkg::index_t idx_pool [4];
    fetch_pkg::tag_t   tag_pool [3];

    int cycle_cnt;
    int n_miss;
    int n_hit;

    fetch_unit UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_req_i  (fetch_req_i),
        .pc_i         (pc_i),
        .ready_o      (ready_o),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .mem_req_o    (mem_req_o),
        .mem_data_i   (mem_data_i)
    );

    always #5 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // little-endian word from the memory model, bits above 17 ignored
    function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t a);
        logic [17:0] w;
        w = {a[17:2], 2'b00};
        return {mem[w + 18'd3], mem[w + 18'd2], mem[w + 18'd1], mem[w]};
    endfunction

    function automatic fetch_pkg::addr_t make_pc();
        logic [13:0] upper;
        logic [1:0]  low;
        upper = 14'($urandom);
        low   = 2'($urandom);
        return {upper, tag_pool[$urandom_range(2)], idx_pool[$urandom_range(3)], low};
    endfunction

    // memory samples the request mid-cycle and checks it against the expected byte address
    always @(negedge clk) begin
        rd_pend = rst_n_i && mem_req_o.rd;
        rd_addr = mem_req_o.addr[17:0];
        if (rd_pend) begin
            assert (exp_rd_q.size() > 0)
            else report_error($sformatf("unexpected memory read at %0d ns, address %h",
                                        $time, mem_req_o.addr));
            assert (mem_req_o.addr == exp_rd_q[0])
            else report_error($sformatf("mismatch at %0d ns: read address %h, expected %h",
                                        $time, mem_req_o.addr, exp_rd_q[0]));
            void'(exp_rd_q.pop_front());
        end
    end

    // byte answer one clock after the read, garbage otherwise
    always @(posedge clk) begin
        #1;
        if (rd_pend) begin
            mem_data_i = mem[rd_addr];
        end else begin
            mem_data_i = fetch_pkg::byte_t'($urandom);
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_error($sformatf("timeout, the run did not finish within %0d cycles",
                                   TIMEOUT_CYCLES));
        end
    end

    // inputs move 1 ns after the edge
    // while busy a strobe now and then, which the DUT must ignore
    task automatic drive_after_edge(input logic busy);
        @(posedge clk);
        #1;
        fetch_req_i = busy && ($urandom_range(2) == 0);
        pc_i        = fetch_pkg::addr_t'($urandom);
    endtask

    task automatic idle_cycle();
        drive_after_edge(1'b0);
        @(negedge clk);
        assert (!inst_valid_o)
        else report_error($sformatf("extra response pulse at %0d ns", $time));
        assert (ready_o)
        else report_error($sformatf("ready low while idle at %0d ns", $time));
    endtask

    // one accepted request, predicted by the reference cache
    task automatic run_request(input fetch_pkg::addr_t pc);
        fetch_pkg::index_t idx;
        fetch_pkg::tag_t   tag;
        fetch_pkg::addr_t  base;
        fetch_pkg::inst_t  exp_word;
        logic              miss;
        int                resp_edge;
        int                j;
        int                k;
        idx  = pc[9:2];
        tag  = pc[17:10];
        base = {pc[31:2], 2'b00};
        miss = !(valid_m[idx] && (tag_m[idx] == tag));
        if (miss) begin
            exp_word = word_at(pc);
            for (k = 0; k < 4; k++) begin
                exp_rd_q.push_back(base + fetch_pkg::addr_t'(k));
            end
            // latest fill wins the line
            valid_m[idx] = 1'b1;
            tag_m[idx]   = tag;
            data_m[idx]  = exp_word;
            resp_edge    = 6;
            n_miss++;
        end else begin
            exp_word  = data_m[idx];
            resp_edge = 0;
            n_hit++;
        end
        @(posedge clk);
        #1;
        fetch_req_i = 1'b1;
        pc_i        = pc;
        @(negedge clk);
        // previous pulse must be gone by now
        assert (ready_o && !inst_valid_o)
        else report_error($sformatf("request at %0d ns found ready low or a stray pulse",
                                    $time));
        // edges counted from the accept edge
        drive_after_edge(miss);
        j = 0;
        @(negedge clk);
        while (!inst_valid_o && (j < resp_edge)) begin
            j++;
            drive_after_edge(miss && (j <= 5));
            @(negedge clk);
        end
        assert (inst_valid_o && (j == resp_edge))
        else report_error($sformatf("mismatch at %0d ns: pc %h answered at edge %0d, expected %0d",
                                    $time, pc, j, resp_edge));
        assert (inst_o == exp_word)
        else report_error($sformatf("mismatch at %0d ns: pc %h inst %h, expected %h",
                                    $time, pc, inst_o, exp_word));
        assert (exp_rd_q.size() == 0)
        else report_error($sformatf("memory reads missing for pc %h at %0d ns", pc, $time));
    endtask

    initial begin
        int i;
        int gap;
        fetch_pkg::tag_t tag0;
        void'($urandom(SEED));
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        fetch_req_i = 1'b0;
        pc_i        = '0;
        mem_data_i  = '0;
        rd_pend     = 1'b0;
        rd_addr     = '0;
        cycle_cnt   = 0;
        n_miss      = 0;
        n_hit       = 0;
        for (i = 0; i < MEM_BYTES; i++) begin
            mem[i] = fetch_pkg::byte_t'($urandom);
        end
        for (i = 0; i < fetch_pkg::CACHE_LINES; i++) begin
            valid_m[i] = 1'b0;
        end
        // three distinct tags, indices may repeat
        tag0 = fetch_pkg::tag_t'($urandom);
        for (i = 0; i < 3; i++) begin
            tag_pool[i] = tag0 + fetch_pkg::tag_t'(i * 85);
        end
        for (i = 0; i < 4; i++) begin
            idx_pool[i] = fetch_pkg::index_t'($urandom);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        assert (ready_o && !inst_valid_o && !mem_req_o.rd)
        else report_error("outputs not in their reset state after reset");
        for (i = 0; i < N_REQ; i++) begin
            gap = $urandom_range(MAX_GAP);
            repeat (gap) idle_cycle();
            run_request(make_pc());
        end
        idle_cycle();
        idle_cycle();
        $display("%0d requests, %0d misses, %0d hits", N_REQ, n_miss, n_hit);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: fetch_unit.f
source/fetch_pkg.sv
source/inst_cache.sv
source/byte_assembler.sv
source/fetch_ctrl.sv
source/fetch_unit.sv
bench/tb_fetch_unit.sv

// File: Makefile
# Verilator build and run for the fetch unit testbench

TOP = tb_fetch_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f fetch_unit.f -o sim

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
